//--- logic/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [31:0]          a,
    input  logic [31:0]          b,
    input  rvCorePkg::aluOpT     op,
    output logic [31:0]          y,
    output logic                 zero,
    output logic                 less,
    output logic                 lessU
);
    import rvCorePkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    // Compare flags for branches, independent of op
    assign zero  = (a == b);
    assign less  = ($signed(a) < $signed(b));
    assign lessU = (a < b);

    always_comb begin
        case (op)
            ALU_ADD:   y = a + b;
            ALU_SUB:   y = a - b;
            ALU_AND:   y = a & b;
            ALU_OR:    y = a | b;
            ALU_XOR:   y = a ^ b;
            ALU_SLL:   y = a << shamt;
            ALU_SRL:   y = a >> shamt;
            ALU_SRA:   y = $unsigned($signed(a) >>> shamt);
            ALU_SLT:   y = {31'b0, less};
            ALU_SLTU:  y = {31'b0, lessU};
            ALU_PASSB: y = b;
            default:   y = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    ctrlIf.decoder ctrl
);
    import rvCorePkg::*;

    always_comb begin
        // No-op unless an opcode below says otherwise
        ctrl.aluOp     = ALU_INVALID;
        ctrl.immSel    = IMM_I;
        ctrl.aluSrcImm = 1'b0;
        ctrl.resultSel = RES_ALU;
        ctrl.regWrite  = 1'b0;
        ctrl.memWrite  = 1'b0;
        ctrl.pcJump    = 1'b0;
        ctrl.jumpReg   = 1'b0;

        case (ctrl.opcode)
            OP_REG: begin
                ctrl.regWrite = 1'b1;
                case (ctrl.funct3)
                    // funct7 bit 5 picks SUB
                    3'b000: ctrl.aluOp = ctrl.funct7b5 ? ALU_SUB : ALU_ADD;
                    3'b001: ctrl.aluOp = ALU_SLL;
                    3'b010: ctrl.aluOp = ALU_SLT;
                    3'b011: ctrl.aluOp = ALU_SLTU;
                    3'b100: ctrl.aluOp = ALU_XOR;
                    3'b101: ctrl.aluOp = ctrl.funct7b5 ? ALU_SRA : ALU_SRL;
                    3'b110: ctrl.aluOp = ALU_OR;
                    default: ctrl.aluOp = ALU_AND;
                endcase
            end

            OP_IMM: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                case (ctrl.funct3)
                    3'b000: ctrl.aluOp = ALU_ADD;
                    3'b001: begin
                        // SLLI with bit 30 set is not a legal encoding
                        if (!ctrl.funct7b5) begin
                            ctrl.aluOp  = ALU_SLL;
                            ctrl.immSel = IMM_IU;
                        end else begin
                            ctrl.regWrite = 1'b0;
                        end
                    end
                    3'b010: ctrl.aluOp = ALU_SLT;
                    3'b011: begin
                        ctrl.aluOp  = ALU_SLTU;
                        ctrl.immSel = IMM_IU;
                    end
                    3'b100: ctrl.aluOp = ALU_XOR;
                    3'b101: begin
                        ctrl.aluOp  = ctrl.funct7b5 ? ALU_SRA : ALU_SRL;
                        ctrl.immSel = IMM_IU;
                    end
                    3'b110: ctrl.aluOp = ALU_OR;
                    default: ctrl.aluOp = ALU_AND;
                endcase
            end

            // Word access only
            OP_LOAD: begin
                if (ctrl.funct3 == 3'b010) begin
                    ctrl.aluOp     = ALU_ADD;
                    ctrl.aluSrcImm = 1'b1;
                    ctrl.resultSel = RES_MEM;
                    ctrl.regWrite  = 1'b1;
                end
            end

            OP_STORE: begin
                if (ctrl.funct3 == 3'b010) begin
                    ctrl.aluOp     = ALU_ADD;
                    ctrl.aluSrcImm = 1'b1;
                    ctrl.immSel    = IMM_S;
                    ctrl.memWrite  = 1'b1;
                end
            end

            OP_LUI: begin
                ctrl.aluOp     = ALU_PASSB;
                ctrl.aluSrcImm = 1'b1;
                ctrl.immSel    = IMM_U;
                ctrl.regWrite  = 1'b1;
            end

            // pc plus upper immediate comes from the target adder
            OP_AUIPC: begin
                ctrl.aluOp     = ALU_ADD;
                ctrl.immSel    = IMM_U;
                ctrl.resultSel = RES_PCTARGET;
                ctrl.regWrite  = 1'b1;
            end

            OP_JAL: begin
                ctrl.aluOp     = ALU_ADD;
                ctrl.immSel    = IMM_J;
                ctrl.resultSel = RES_PC4;
                ctrl.regWrite  = 1'b1;
                ctrl.pcJump    = 1'b1;
            end

            // Target is rs1 plus immediate, computed in the ALU
            OP_JALR: begin
                ctrl.aluOp     = ALU_ADD;
                ctrl.aluSrcImm = 1'b1;
                ctrl.resultSel = RES_PC4;
                ctrl.regWrite  = 1'b1;
                ctrl.pcJump    = 1'b1;
                ctrl.jumpReg   = 1'b1;
            end

            OP_BRANCH: begin
                ctrl.aluOp  = ALU_SUB;
                ctrl.immSel = IMM_B;
                case (ctrl.funct3)
                    3'b000: ctrl.pcJump = ctrl.zero;
                    3'b001: ctrl.pcJump = ~ctrl.zero;
                    3'b100: ctrl.pcJump = ctrl.less;
                    3'b101: ctrl.pcJump = ~ctrl.less;
                    3'b110: ctrl.pcJump = ctrl.lessU;
                    3'b111: ctrl.pcJump = ~ctrl.lessU;
                    default: ctrl.pcJump = 1'b0;
                endcase
            end

            default: begin
                ctrl.aluOp = ALU_INVALID;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/ctrlIf.sv
`timescale 1ns/1ps
`default_nettype none

interface ctrlIf;
    import rvCorePkg::*;

    // Decoded controls
    aluOpT      aluOp;
    immSelT     immSel;
    logic       aluSrcImm;
    resultSelT  resultSel;
    logic       regWrite;
    logic       memWrite;
    logic       pcJump;
    logic       jumpReg;

    // Instruction fields and ALU flags from the datapath
    opcodeT     opcode;
    logic [2:0] funct3;
    logic       funct7b5;
    logic       zero;
    logic       less;
    logic       lessU;

    modport decoder (
        input  opcode, funct3, funct7b5, zero, less, lessU,
        output aluOp, immSel, aluSrcImm, resultSel, regWrite, memWrite, pcJump, jumpReg
    );

    modport datapath (
        output opcode, funct3, funct7b5, zero, less, lessU,
        input  aluOp, immSel, aluSrcImm, resultSel, regWrite, memWrite, pcJump, jumpReg
    );

endinterface

`default_nettype wire

//--- logic/dataMem.sv
`timescale 1ns/1ps
`default_nettype none

module dataMem #(
    parameter int dataMemWords = 256
) (
    input  logic        clk,
    input  logic        we,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata
);

    localparam int indexBits = $clog2(dataMemWords);

    logic [31:0]          mem [dataMemWords];
    logic [indexBits-1:0] index;

    // Byte offset bits are ignored
    assign index = addr[indexBits+1:2];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[index] <= wdata;
        end
    end

    assign rdata = mem[index];

endmodule

`default_nettype wire

//--- logic/immGen.sv
`timescale 1ns/1ps
`default_nettype none

module immGen (
    input  logic [31:0]           instr,
    input  rvCorePkg::immSelT     immSel,
    output logic [31:0]           imm
);
    import rvCorePkg::*;

    always_comb begin
        case (immSel)
            // Shift and unsigned forms use the plain I layout
            IMM_I, IMM_IU: begin
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            IMM_S: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            IMM_B: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            IMM_U: begin
                imm = {instr[31:12], 12'b0};
            end
            IMM_J: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic        clk,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    // x1 to x31, x0 has no storage
    logic [31:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads as zero
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

`default_nettype wire

//--- logic/rvCore.sv
`timescale 1ns/1ps
`default_nettype none

module rvCore #(
    parameter int dataMemWords = 256
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] instr,
    output logic [31:0] pc,
    output logic        wbEn,
    output logic [4:0]  wbAddr,
    output logic [31:0] wbData
);

    // Decoded controls and ALU flags
    ctrlIf ctrlBus ();

    controlUnit uControlUnit (
        .ctrl (ctrlBus.decoder)
    );

    rvDatapath #(
        .dataMemWords (dataMemWords)
    ) uDatapath (
        .clk    (clk),
        .reset  (reset),
        .instr  (instr),
        .ctrl   (ctrlBus.datapath),
        .pc     (pc),
        .wbEn   (wbEn),
        .wbAddr (wbAddr),
        .wbData (wbData)
    );

endmodule

`default_nettype wire

//--- logic/rvCorePkg.sv
`default_nettype none

package rvCorePkg;

    // ALU operation codes, unused 1000 kept free
    typedef enum logic [3:0] {
        ALU_ADD     = 4'b0000,
        ALU_SUB     = 4'b0001,
        ALU_AND     = 4'b0010,
        ALU_OR      = 4'b0011,
        ALU_XOR     = 4'b0100,
        ALU_SLL     = 4'b0101,
        ALU_SRL     = 4'b0110,
        ALU_SRA     = 4'b0111,
        ALU_SLT     = 4'b1001,
        ALU_SLTU    = 4'b1010,
        ALU_PASSB   = 4'b1011,
        ALU_INVALID = 4'b1111
    } aluOpT;

    // Immediate formats
    typedef enum logic [2:0] {
        IMM_I  = 3'b000,
        IMM_IU = 3'b001,
        IMM_S  = 3'b010,
        IMM_B  = 3'b011,
        IMM_U  = 3'b100,
        IMM_J  = 3'b101
    } immSelT;

    // Major opcodes
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_IMM    = 7'b0010011,
        OP_AUIPC  = 7'b0010111,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111
    } opcodeT;

    // Writeback source
    typedef enum logic [1:0] {
        RES_ALU      = 2'b00,
        RES_MEM      = 2'b01,
        RES_PC4      = 2'b10,
        RES_PCTARGET = 2'b11
    } resultSelT;

endpackage

`default_nettype wire

//--- logic/rvDatapath.sv
`timescale 1ns/1ps
`default_nettype none

module rvDatapath #(
    parameter int dataMemWords = 256
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] instr,
    ctrlIf.datapath     ctrl,
    output logic [31:0] pc,
    output logic        wbEn,
    output logic [4:0]  wbAddr,
    output logic [31:0] wbData
);
    import rvCorePkg::*;

    logic [31:0] imm;
    logic [31:0] rdata1;
    logic [31:0] rdata2;
    logic [31:0] srcB;
    logic [31:0] aluY;
    logic [31:0] memRdata;
    logic [31:0] pcPlus4;
    logic [31:0] pcTarget;
    logic [31:0] pcNext;

    // Instruction fields for the decoder
    assign ctrl.opcode   = opcodeT'(instr[6:0]);
    assign ctrl.funct3   = instr[14:12];
    assign ctrl.funct7b5 = instr[30];

    immGen uImmGen (
        .instr  (instr),
        .immSel (ctrl.immSel),
        .imm    (imm)
    );

    regFile uRegFile (
        .clk    (clk),
        .raddr1 (instr[19:15]),
        .raddr2 (instr[24:20]),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (ctrl.regWrite),
        .waddr  (instr[11:7]),
        .wdata  (wbData)
    );

    assign srcB = ctrl.aluSrcImm ? imm : rdata2;

    alu uAlu (
        .a     (rdata1),
        .b     (srcB),
        .op    (ctrl.aluOp),
        .y     (aluY),
        .zero  (ctrl.zero),
        .less  (ctrl.less),
        .lessU (ctrl.lessU)
    );

    dataMem #(
        .dataMemWords (dataMemWords)
    ) uDataMem (
        .clk   (clk),
        .we    (ctrl.memWrite),
        .addr  (aluY),
        .wdata (rdata2),
        .rdata (memRdata)
    );

    assign pcPlus4  = pc + 32'd4;
    assign pcTarget = pc + imm;

    // JALR target from the ALU sum with bit 0 cleared
    assign pcNext = !ctrl.pcJump ? pcPlus4 :
                    ctrl.jumpReg ? {aluY[31:1], 1'b0} : pcTarget;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    always_comb begin
        case (ctrl.resultSel)
            RES_ALU:      wbData = aluY;
            RES_MEM:      wbData = memRdata;
            RES_PC4:      wbData = pcPlus4;
            default:      wbData = pcTarget;
        endcase
    end

    // Writes to x0 are not reported
    assign wbAddr = instr[11:7];
    assign wbEn   = ctrl.regWrite && (wbAddr != 5'd0);

endmodule

`default_nettype wire

//--- verification/rvCoreStim.txt
// instr pc wbEn wbAddr wbData in hex, one line per cycle; wbAddr and wbData unchecked if wbEn is 0
00000013 00000000 0 00 00000000
00500093 00000004 1 01 00000005
ffd00113 00000008 1 02 fffffffd
800001b7 0000000c 1 03 80000000
00208233 00000010 1 04 00000002
402082b3 00000014 1 05 00000008
0020f333 00000018 1 06 00000005
0020e3b3 0000001c 1 07 fffffffd
0020c433 00000020 1 08 fffffff8
001114b3 00000024 1 09 ffffffa0
00115533 00000028 1 0a 07ffffff
401155b3 0000002c 1 0b ffffffff
00112633 00000030 1 0c 00000001
001136b3 00000034 1 0d 00000000
4041d713 00000038 1 0e f8000000
fff0b793 0000003c 1 0f 00000001
00708013 00000040 0 00 00000000
00100833 00000044 1 10 00000005
00502423 00000048 0 00 00000000
00802623 0000004c 0 00 00000000
00802883 00000050 1 11 00000008
00c02903 00000054 1 12 fffffff8
00110463 00000058 0 00 00000000
00108463 0000005c 0 00 00000000
00111463 00000064 0 00 00000000
00109463 0000006c 0 00 00000000
00114463 00000070 0 00 00000000
0020c463 00000078 0 00 00000000
00115463 0000007c 0 00 00000000
0020d463 00000080 0 00 00000000
00116463 00000088 0 00 00000000
0020e463 0000008c 0 00 00000000
00117463 00000094 0 00 00000000
0020f463 0000009c 0 00 00000000
00001997 000000a0 1 13 000010a0
00c00a6f 000000a4 1 14 000000a8
0c478b67 000000b0 1 16 000000b4
00000013 000000c4 0 00 00000000

//--- verification/rvCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module rvCoreTb;

    localparam string stimFile = "verification/rvCoreStim.txt";

    logic        clk;
    logic        reset;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        wbEn;
    logic [4:0]  wbAddr;
    logic [31:0] wbData;

    // One entry per program line
    logic [31:0] instrQ [$];
    logic [31:0] pcQ [$];
    logic        wbEnQ [$];
    logic [4:0]  wbAddrQ [$];
    logic [31:0] wbDataQ [$];

    int errorCount;
    int checkCount;
    int cycleCount;
    int lineCount;

    rvCore #(
        .dataMemWords (256)
    ) i_dut (
        .clk    (clk),
        .reset  (reset),
        .instr  (instr),
        .pc     (pc),
        .wbEn   (wbEn),
        .wbAddr (wbAddr),
        .wbData (wbData)
    );

    initial begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
        checkCount++;
        if (got !== expected) begin
            errorCount++;
            $display("[FAIL] time %0t: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic loadProgram;
        int          fd;
        string       line;
        logic [31:0] fInstr;
        logic [31:0] fPc;
        logic [31:0] fEn;
        logic [31:0] fAddr;
        logic [31:0] fData;
        fd = $fopen(stimFile, "r");
        if (fd == 0) begin
            errorCount++;
            $display("Could not open the stimulus file %s", stimFile);
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // Comment and blank lines do not give five fields
                if ($sscanf(line, "%h %h %h %h %h", fInstr, fPc, fEn, fAddr, fData) == 5) begin
                    instrQ.push_back(fInstr);
                    pcQ.push_back(fPc);
                    wbEnQ.push_back(fEn[0]);
                    wbAddrQ.push_back(fAddr[4:0]);
                    wbDataQ.push_back(fData);
                end
            end
            $fclose(fd);
        end
    endtask

    // Watchdog sized from the program length
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > lineCount + 20) begin
            $display("Timeout: the run went past %0d cycles", lineCount + 20);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        errorCount = 0;
        checkCount = 0;
        cycleCount = 0;
        reset      = 1'b1;
        instr      = 32'h0000_0013;
        loadProgram();
        lineCount = instrQ.size();
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int n = 0; n < lineCount; n++) begin
            instr = instrQ[n];
            // Sample halfway to the next rising edge
            #10;
            checkValue($sformatf("line %0d pc", n), pc, pcQ[n]);
            checkValue($sformatf("line %0d wbEn", n), {31'b0, wbEn}, {31'b0, wbEnQ[n]});
            if (wbEnQ[n]) begin
                checkValue($sformatf("line %0d wbAddr", n), {27'b0, wbAddr}, {27'b0, wbAddrQ[n]});
                checkValue($sformatf("line %0d wbData", n), wbData, wbDataQ[n]);
            end
            @(negedge clk);
        end
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
logic/rvCorePkg.sv
logic/ctrlIf.sv
logic/immGen.sv
logic/alu.sv
logic/regFile.sv
logic/dataMem.sv
logic/controlUnit.sv
logic/rvDatapath.sv
logic/rvCore.sv
verification/rvCoreTb.sv
